/* bench/bus_memory_model.sv */
module bus_memory_model (
    input  logic                  clk,
    input  logic                  reset,
    input  z80_bus_pkg::z80_bus_t bus,
    input  logic [15:0]           exp_addr,
    input  logic [3:0]            ext_waits,
    output logic [7:0]            d_in,
    output logic                  n_wait,
    output logic                  bus_error
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] mem [0:65535];
    logic [3:0] low_halves;  // Falling edges seen with nMREQ low

    initial begin
        bus_error  = 1'b0;
        low_halves = '0;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = i[15:8] ^ i[7:0] ^ 8'h5a;
        end
    end

    assign d_in   = !bus.n_rd ? mem[bus.a] : 8'hff;  // Drives data only under nRD
    assign n_wait = (low_halves >= ext_waits);       // Low for T2 and ext_waits-1 Twaits

    always @(negedge clk) begin
        if (reset || bus.n_mreq) begin
            low_halves <= '0;
        end else if (low_halves != 4'hf) begin
            low_halves <= low_halves + 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!reset && !bus.n_wr && bus.d_out_en) begin
            mem[bus.a] <= bus.d_out;
        end
    end

    // Strobe rules, checked in both halves of every T-state
    always @(posedge clk or negedge clk) begin
        if (reset === 1'b0) begin
            if (!bus.n_rd && !bus.n_wr) begin
                $display("nRD and nWR are low at the same time");
                bus_error = 1'b1;
            end
            if (!bus.n_rd && bus.d_out_en) begin
                $display("data bus driven by the CPU while nRD is low");
                bus_error = 1'b1;
            end
            if ((!bus.n_rd || !bus.n_wr) && bus.n_mreq) begin
                $display("nRD or nWR is low while nMREQ is high");
                bus_error = 1'b1;
            end
            if (!bus.n_mreq && bus.a !== exp_addr) begin
                $display("MISMATCH bus.a got %h expected %h", bus.a, exp_addr);
                bus_error = 1'b1;
            end
        end
    end

endmodule

/* bench/z80_bus_tests.txt */
# kind auto_waits ext_waits addr wdata exp_rdata exp_wait_states (all hex)
# auto_waits is loaded by CFG only; unwritten bytes read addr_hi ^ addr_lo ^ 5a
RD  0 0 1234 00 7c 0
RD  0 0 0000 00 5a 0
WR  0 0 1000 a5 00 0
RD  0 0 1000 00 a5 0
WR  0 0 ffff 3c 00 0
RD  0 0 ffff 00 3c 0
CFG 1 0 0000 00 00 0
WR  1 0 2001 11 00 1
RD  1 0 2001 00 11 1
CFG 2 0 0000 00 00 0
WR  2 0 2002 22 00 2
RD  2 0 2002 00 22 2
CFG 3 0 0000 00 00 0
WR  3 0 2003 33 00 3
RD  3 0 00ff 00 a5 3
CFG 0 0 0000 00 00 0
WR  0 1 3001 44 00 1
RD  0 2 3001 00 44 2
RD  0 4 2003 00 33 4
CFG 2 0 0000 00 00 0
WR  2 1 3002 55 00 2
RD  2 3 3002 00 55 3
CFG 1 0 0000 00 00 0
WR  1 5 4321 66 00 5
RD  1 0 4321 00 66 1
RD  1 0 abcd 00 3c 1

/* bench/z80_bus_unit_tb.sv */
module z80_bus_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                   clk;
    logic                   reset;
    logic                   req;
    logic                   cfg_we;
    logic                   busy;
    logic                   resp_valid;
    logic                   bus_error;
    logic [7:0]             d_in;
    logic                   n_wait;
    logic [15:0]            exp_addr;
    logic [3:0]             ext_waits;  // External waits the memory model inserts
    z80_bus_pkg::mem_cmd_t  cmd;
    z80_bus_pkg::wait_cfg_t cfg_data;
    z80_bus_pkg::mem_resp_t resp;
    z80_bus_pkg::z80_bus_t  bus;

    always #2 clk = ~clk;

    z80_bus_unit #(.WAIT_CNT_W(4)) uut (.*);

    bus_memory_model u_mem (.*);

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    always @(posedge bus_error) begin
        report_failure("the memory model saw an illegal bus cycle");
    end

    // Drive point sits just after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic check_resp(input z80_bus_pkg::mem_resp_t got,
                              input z80_bus_pkg::mem_resp_t exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH resp got %h expected %h", got, exp));
        end
    endtask

    task automatic check_bus_idle(input z80_bus_pkg::z80_bus_t got);
        z80_bus_pkg::z80_bus_t exp;
        exp          = got;
        exp.d_out_en = 1'b0;
        exp.n_mreq   = 1'b1;
        exp.n_rd     = 1'b1;
        exp.n_wr     = 1'b1;
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH bus got %h expected %h", got, exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("MISMATCH latency got %h expected %h", got, exp));
        end
    endtask

    task automatic write_config(input int auto_w);
        cfg_data.auto_waits = auto_w[1:0];
        cfg_we              = 1'b1;
        step_cycle();
        cfg_we = 1'b0;
    endtask

    task automatic run_command(input z80_bus_pkg::mem_op_e op, input int addr_v, input int wdata_v,
                               input int ext_w, input z80_bus_pkg::mem_resp_t exp_resp);
        int                    n;
        int                    latency;
        z80_bus_pkg::mem_cmd_t first;
        first.op    = op;
        first.addr  = addr_v[15:0];
        first.wdata = wdata_v[7:0];
        exp_addr    = first.addr;
        ext_waits   = ext_w[3:0];
        cmd         = first;
        req         = 1'b1;
        latency     = -1;
        for (n = 0; n < 40 && latency < 0; n++) begin
            step_cycle();
            if (resp_valid === 1'b1) begin
                latency = n;
            end else if (n == 0) begin
                if (busy !== 1'b1) begin
                    report_failure("busy did not rise after an accepted request");
                end
                // A conflicting command while busy, held for one edge
                cmd.op    = (op == z80_bus_pkg::OP_READ) ? z80_bus_pkg::OP_WRITE
                                                          : z80_bus_pkg::OP_READ;
                cmd.addr  = ~first.addr;
                cmd.wdata = ~first.wdata;
            end else begin
                req = 1'b0;
            end
        end
        req = 1'b0;
        if (latency < 0) begin
            report_failure("no response within 40 cycles of the request");
        end
        check_latency(latency, 4 + exp_resp.wait_states);
        check_resp(resp, exp_resp);
        repeat (6) begin
            step_cycle();
            check_bus_idle(bus);
            if (resp_valid !== 1'b0) begin
                report_failure("a second response followed the first one");
            end
        end
    endtask

    initial begin
        int               fd;
        int               code;
        int               tests;
        int               auto_w, ext_w, addr_v, wdata_v, rdata_v, waits_v;
        logic [63:0]      kind;
        logic [8*120-1:0] rest;
        reset     = 1'b1;
        clk       = 1'b0;
        req       = 1'b0;
        cmd       = '0;
        cfg_we    = 1'b0;
        cfg_data  = '0;
        exp_addr  = '0;
        ext_waits = '0;
        tests     = 0;
        repeat (2) @(posedge clk);
        #0.5;
        reset = 1'b0;
        check_bus_idle(bus);
        if (resp_valid !== 1'b0) begin
            report_failure("resp_valid is high after reset");
        end
        fd = $fopen("bench/z80_bus_tests.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open the test file bench/z80_bus_tests.txt");
        end
        code = $fscanf(fd, "%s", kind);
        while (code == 1) begin
            if (kind == "#") begin
                code = $fgets(rest, fd);  // Skip a note line
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h %h",
                               auto_w, ext_w, addr_v, wdata_v, rdata_v, waits_v);
                if (code != 6) begin
                    report_failure("a line of the test file has too few fields");
                end
                case (kind)
                    "CFG": write_config(auto_w);
                    "WR": run_command(z80_bus_pkg::OP_WRITE, addr_v, wdata_v, ext_w,
                                      {rdata_v[7:0], waits_v[3:0]});
                    "RD": run_command(z80_bus_pkg::OP_READ, addr_v, wdata_v, ext_w,
                                      {rdata_v[7:0], waits_v[3:0]});
                    default: report_failure("unknown test kind in the test file");
                endcase
                tests++;
            end
            code = $fscanf(fd, "%s", kind);
        end
        $fclose(fd);
        if (tests == 0) begin
            report_failure("the test file held no tests");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

/* source/mem_cycle.sv */
module mem_cycle (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 activate,
    input  z80_bus_pkg::mem_op_e op,
    input  logic [15:0]          addr,
    input  logic [7:0]           wdata,
    input  logic [7:0]           d_in,
    input  logic                 n_wait,
    output z80_bus_pkg::z80_bus_t bus,
    output z80_bus_pkg::tstate_e  tstate,
    output logic [7:0]           rdata,
    output logic                 done
);

    logic clk_rise;       // Toggles on every rising edge
    logic clk_fall;       // Follows clk_rise on every falling edge
    logic clk_state;      // High in the first half of a T-state
    logic do_rd;
    logic do_wr;
    logic latched_nwait;
    logic cycle_start;

    // Clock clone built from registers only
    assign clk_state = clk_rise ^ clk_fall;

    // A new cycle starts from idle or chains out of T3
    assign cycle_start = activate &&
        (tstate == z80_bus_pkg::T_IDLE || tstate == z80_bus_pkg::T3);

    always_ff @(posedge clk) begin
        if (reset) begin
            tstate   <= z80_bus_pkg::T_IDLE;
            do_rd    <= 1'b0;
            do_wr    <= 1'b0;
            clk_rise <= 1'b0;
        end else begin
            clk_rise <= ~clk_rise;

            case (tstate)
                z80_bus_pkg::T_IDLE:
                    tstate <= activate ? z80_bus_pkg::T1 : z80_bus_pkg::T_IDLE;
                z80_bus_pkg::T1:
                    tstate <= z80_bus_pkg::T2;
                z80_bus_pkg::T2:
                    tstate <= latched_nwait ? z80_bus_pkg::T3 : z80_bus_pkg::T_WAIT;
                z80_bus_pkg::T_WAIT:
                    tstate <= latched_nwait ? z80_bus_pkg::T3 : z80_bus_pkg::T_WAIT;
                z80_bus_pkg::T3:
                    tstate <= activate ? z80_bus_pkg::T1 : z80_bus_pkg::T_IDLE;
                default:
                    tstate <= z80_bus_pkg::T_IDLE;
            endcase

            if (cycle_start) begin
                do_rd <= (op == z80_bus_pkg::OP_READ);
                do_wr <= (op == z80_bus_pkg::OP_WRITE);
            end
        end
    end

    always_ff @(negedge clk) begin
        if (reset) begin
            clk_fall      <= 1'b0;
            latched_nwait <= 1'b1;
        end else begin
            clk_fall <= clk_rise;
            // nWAIT is sampled mid T2 and mid every Twait
            if (tstate == z80_bus_pkg::T2 || tstate == z80_bus_pkg::T_WAIT) begin
                latched_nwait <= n_wait;
            end
        end
    end

    // Read data taken at the falling edge inside T3
    always_ff @(negedge clk) begin
        if (tstate == z80_bus_pkg::T3) begin
            rdata <= d_in;
        end
    end

    always_comb begin
        bus.a        = addr;
        bus.d_out    = wdata;
        bus.n_mreq   = 1'b1;
        bus.n_rd     = 1'b1;
        bus.n_wr     = 1'b1;
        bus.d_out_en = 1'b0;
        done         = 1'b0;

        case (tstate)
            z80_bus_pkg::T1: begin
                bus.n_mreq   = clk_state;            // Falls mid T1
                bus.n_rd     = do_rd ? clk_state : 1'b1;
                bus.d_out_en = do_wr && !clk_state;  // Data ahead of nWR
            end
            z80_bus_pkg::T2: begin
                bus.n_mreq   = 1'b0;
                bus.n_rd     = !do_rd;
                bus.n_wr     = do_wr ? clk_state : 1'b1;  // nWR falls mid T2
                bus.d_out_en = do_wr;
            end
            z80_bus_pkg::T_WAIT: begin
                bus.n_mreq   = 1'b0;
                bus.n_rd     = !do_rd;
                bus.n_wr     = !do_wr;
                bus.d_out_en = do_wr;
            end
            z80_bus_pkg::T3: begin
                // Strobes release at the falling edge of T3
                bus.n_mreq   = !clk_state;
                bus.n_rd     = do_rd ? !clk_state : 1'b1;
                bus.n_wr     = do_wr ? !clk_state : 1'b1;
                bus.d_out_en = do_wr;
                done         = !clk_state;
            end
            default: begin
            end
        endcase

        if (reset) begin
            bus.n_mreq   = 1'b1;
            bus.n_rd     = 1'b1;
            bus.n_wr     = 1'b1;
            bus.d_out_en = 1'b0;
            done         = 1'b0;
        end
    end

endmodule

/* source/mem_cycle_ctrl.sv */
module mem_cycle_ctrl #(
    parameter int WAIT_CNT_W = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  z80_bus_pkg::mem_cmd_t  cmd,
    input  logic                   done,
    input  logic [7:0]             rdata,
    input  logic [WAIT_CNT_W-1:0]  wait_count,
    input  z80_bus_pkg::tstate_e   tstate,
    output logic                   busy,
    output logic                   activate,
    output z80_bus_pkg::mem_op_e   op,
    output logic [15:0]            addr,
    output logic [7:0]             wdata,
    output logic                   resp_valid,
    output z80_bus_pkg::mem_resp_t resp
);

    z80_bus_pkg::mem_cmd_t cmd_q;  // Command held for the whole cycle
    logic                  accept;
    logic                  finish;

    // Requests during a cycle are dropped
    assign accept = req && !busy;

    // done is sampled at the rising edge that ends T3
    assign finish = busy && !activate && done;

    assign op    = cmd_q.op;
    assign addr  = cmd_q.addr;
    assign wdata = cmd_q.wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            activate   <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;

            if (accept) begin
                busy     <= 1'b1;
                activate <= 1'b1;
            end

            // Cycle block leaves idle on this same edge
            if (activate && tstate == z80_bus_pkg::T_IDLE) begin
                activate <= 1'b0;
            end

            if (finish) begin
                busy       <= 1'b0;
                resp_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= cmd;
        end
        if (finish) begin
            // Writes report zero read data
            resp.rdata       <= (cmd_q.op == z80_bus_pkg::OP_READ) ? rdata : 8'h00;
            resp.wait_states <= 4'(wait_count);
        end
    end

endmodule

/* source/wait_state_config.sv */
module wait_state_config #(
    parameter int WAIT_CNT_W = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cfg_we,
    input  z80_bus_pkg::wait_cfg_t cfg_data,
    input  z80_bus_pkg::tstate_e   tstate,
    input  logic                   n_wait,
    output logic                   n_wait_int,
    output logic [WAIT_CNT_W-1:0]  wait_count
);

    z80_bus_pkg::wait_cfg_t cfg_q;
    logic [WAIT_CNT_W:0]    waits_passed;  // One bit wider, never wraps
    logic [WAIT_CNT_W:0]    auto_ext;

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_q <= '0;
        end else if (cfg_we) begin
            cfg_q <= cfg_data;
        end
    end

    // Twait counter, restarts with every T1
    always_ff @(posedge clk) begin
        if (reset) begin
            wait_count <= '0;
        end else if (tstate == z80_bus_pkg::T1) begin
            wait_count <= '0;
        end else if (tstate == z80_bus_pkg::T_WAIT && wait_count != '1) begin
            wait_count <= wait_count + 1'b1;
        end
    end

    // The current Twait counts as passed when nWAIT is sampled mid-state
    always_comb begin
        waits_passed = {1'b0, wait_count};
        if (tstate == z80_bus_pkg::T_WAIT) begin
            waits_passed = waits_passed + 1'b1;
        end
    end

    assign auto_ext = (WAIT_CNT_W + 1)'(cfg_q.auto_waits);

    // Internal waits first, then the external pin decides
    assign n_wait_int = n_wait && (waits_passed >= auto_ext);

endmodule

/* source/z80_bus_pkg.sv */
package z80_bus_pkg;

    // Operation of a host memory command
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // Machine cycle T-states
    typedef enum logic [2:0] {
        T_IDLE = 3'd0,
        T1     = 3'd1,
        T2     = 3'd2,
        T3     = 3'd3,
        T_WAIT = 3'd7  // Twait keeps its historic code
    } tstate_e;

    typedef struct packed {
        mem_op_e     op;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } mem_cmd_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic [3:0] wait_states;
    } mem_resp_t;

    // Pin side of the bus, strobes active low
    typedef struct packed {
        logic [15:0] a;
        logic [7:0]  d_out;
        logic        d_out_en;
        logic        n_mreq;
        logic        n_rd;
        logic        n_wr;
    } z80_bus_t;

    typedef struct packed {
        logic [1:0] auto_waits;  // Wait states inserted on every cycle
    } wait_cfg_t;

endpackage

/* source/z80_bus_unit.sv */
module z80_bus_unit #(
    parameter int WAIT_CNT_W = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  z80_bus_pkg::mem_cmd_t  cmd,
    input  logic                   cfg_we,
    input  z80_bus_pkg::wait_cfg_t cfg_data,
    input  logic [7:0]             d_in,
    input  logic                   n_wait,
    output logic                   busy,
    output logic                   resp_valid,
    output z80_bus_pkg::mem_resp_t resp,
    output z80_bus_pkg::z80_bus_t  bus
);

    logic                  activate;
    z80_bus_pkg::mem_op_e  op;
    logic [15:0]           addr;
    logic [7:0]            wdata;
    logic [7:0]            rdata;
    logic                  done;
    z80_bus_pkg::tstate_e  tstate;
    logic                  n_wait_int;  // Pin nWAIT merged with auto waits
    logic [WAIT_CNT_W-1:0] wait_count;

    mem_cycle_ctrl #(
        .WAIT_CNT_W(WAIT_CNT_W)
    ) u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .cmd       (cmd),
        .done      (done),
        .rdata     (rdata),
        .wait_count(wait_count),
        .tstate    (tstate),
        .busy      (busy),
        .activate  (activate),
        .op        (op),
        .addr      (addr),
        .wdata     (wdata),
        .resp_valid(resp_valid),
        .resp      (resp)
    );

    mem_cycle u_cycle (
        .clk     (clk),
        .reset   (reset),
        .activate(activate),
        .op      (op),
        .addr    (addr),
        .wdata   (wdata),
        .d_in    (d_in),
        .n_wait  (n_wait_int),
        .bus     (bus),
        .tstate  (tstate),
        .rdata   (rdata),
        .done    (done)
    );

    wait_state_config #(
        .WAIT_CNT_W(WAIT_CNT_W)
    ) u_wait_cfg (
        .clk       (clk),
        .reset     (reset),
        .cfg_we    (cfg_we),
        .cfg_data  (cfg_data),
        .tstate    (tstate),
        .n_wait    (n_wait),
        .n_wait_int(n_wait_int),
        .wait_count(wait_count)
    );

endmodule

/* z80_bus_unit.f */
source/z80_bus_pkg.sv
source/mem_cycle.sv
source/wait_state_config.sv
source/mem_cycle_ctrl.sv
source/z80_bus_unit.sv
bench/bus_memory_model.sv
bench/z80_bus_unit_tb.sv
